/* bench/tb_vc_map.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_vc_map;

    logic                   clk;
    logic                   reset;
    logic                   rd_valid;
    vc_map_pkg::line_addr_t rd_addr;
    vc_map_pkg::vc_t        rd_vc;
    logic                   wr_valid;
    vc_map_pkg::line_addr_t wr_addr;
    vc_map_pkg::vc_t        wr_vc;
    logic                   rd_alm_full;
    logic                   wr_alm_full;
    logic                   rd_out_valid;
    vc_map_pkg::line_addr_t rd_out_addr;
    vc_map_pkg::vc_t        rd_out_vc;
    logic                   wr_out_valid;
    vc_map_pkg::line_addr_t wr_out_addr;
    vc_map_pkg::vc_t        wr_out_vc;
    logic                   wr_out_fence;
    logic                   rd_alm_full_in;
    logic                   wr_alm_full_in;
    logic                   rd_rsp;
    logic                   wr_rsp;
    logic                   fence_rsp;
    logic                   ctrl_valid;
    logic                   ctrl_rd_map_en;
    logic                   ctrl_wr_map_en;
    vc_map_pkg::ratio_t     ctrl_ratio;
    vc_map_pkg::ratio_t     ratio;
    logic                   mapping_changed;
    int                     error_count;

    logic [15:0] lfsr;
    int          cyc;
    int          timeouts;
    int          fence_due;
    int          rd_last;
    int          wr_last;
    int          rd_due[$];
    int          wr_due[$];
    logic        ctrl_req;
    logic        req_rd_en;
    logic        req_wr_en;
    logic [5:0]  req_ratio;
    logic        bp_en;

    vc_map_top i_vc_map_top (.*);

    vc_map_checker i_checker (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    // ====================
    // Random source
    // ====================

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11 stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Picks the next free response slot 3 to 10 cycles out so no two responses share a cycle
    task automatic schedule_rsp(inout int last, output int due);
        logic [31:0] d;
        d = take_bits(3);
        due = cyc + 3 + int'(d);
        if (due <= last)
        begin
            due = last + 1;
        end
        last = due;
    endtask

    // ====================
    // Per-cycle driver
    // ====================

    // Answers platform requests and drives the client 1 ns after the edge
    task automatic drive_cycle(input logic send);
        logic [31:0] v;
        int          due;
        @(posedge clk);
        #1;
        cyc++;
        if (rd_out_valid)
        begin
            schedule_rsp(rd_last, due);
            rd_due.push_back(due);
        end
        if (wr_out_valid && !wr_out_fence)
        begin
            schedule_rsp(wr_last, due);
            wr_due.push_back(due);
        end
        if (wr_out_fence)
        begin
            fence_due = cyc + 4;
        end
        rd_rsp = (rd_due.size() > 0) && (rd_due[0] <= cyc);
        if (rd_rsp)
        begin
            void'(rd_due.pop_front());
        end
        wr_rsp = (wr_due.size() > 0) && (wr_due[0] <= cyc);
        if (wr_rsp)
        begin
            void'(wr_due.pop_front());
        end
        fence_rsp = (cyc == fence_due);

        // A small address pool makes lines repeat and most requests ask for VA
        v = take_bits(1);
        rd_valid = send && !rd_alm_full && v[0];
        v = take_bits(7);
        rd_addr = vc_map_pkg::line_addr_t'({v[6:0], 6'h15});
        v = take_bits(2);
        rd_vc = (v[1:0] == 2'd3) ? vc_map_pkg::vc_t'(cyc % 4) : vc_map_pkg::VC_VA;
        v = take_bits(1);
        wr_valid = send && !wr_alm_full && v[0];
        v = take_bits(7);
        wr_addr = vc_map_pkg::line_addr_t'({v[6:0], 6'h2a});
        v = take_bits(2);
        wr_vc = (v[1:0] == 2'd3) ? vc_map_pkg::vc_t'(cyc % 4) : vc_map_pkg::VC_VA;

        ctrl_valid = ctrl_req;
        ctrl_rd_map_en = req_rd_en;
        ctrl_wr_map_en = req_wr_en;
        ctrl_ratio = req_ratio;
        ctrl_req = 1'b0;

        // Occasional platform back-pressure, seen by the client from the next cycle on
        v = take_bits(3);
        rd_alm_full_in = bp_en && (v[2:0] == 3'd0);
        v = take_bits(3);
        wr_alm_full_in = bp_en && (v[2:0] == 3'd0);
    endtask

    task automatic run_traffic(input int n);
        for (int i = 0; i < n; i++)
        begin
            drive_cycle(1'b1);
        end
    endtask

    task automatic write_ctrl(input logic rd_en, input logic wr_en, input logic [5:0] r);
        ctrl_req = 1'b1;
        req_rd_en = rd_en;
        req_wr_en = wr_en;
        req_ratio = r;
        drive_cycle(1'b1);
    endtask

    // Runs a full re-mapping with every step bounded by its own timeout
    // The platform holds off its own back-pressure for the whole sequence so
    // the release of the hold shows on both almost-full outputs
    task automatic remap(input logic [5:0] r);
        int n;
        bp_en = 1'b0;
        write_ctrl(1'b1, 1'b1, r);
        n = 0;
        while (!mapping_changed && (n < 400))
        begin
            drive_cycle(1'b1);
            n++;
        end
        if (!mapping_changed)
        begin
            $display("Timeout: mapping_changed never pulsed for ratio %0d", r);
            timeouts++;
        end
        n = 0;
        while ((rd_alm_full || wr_alm_full) && (n < 400))
        begin
            drive_cycle(1'b1);
            n++;
        end
        if (rd_alm_full || wr_alm_full)
        begin
            $display("Timeout: almost-full was never released after re-mapping");
            timeouts++;
        end
        bp_en = 1'b1;
    endtask

    initial
    begin
        lfsr = 16'd48;
        cyc = 0;
        timeouts = 0;
        fence_due = -1;
        rd_last = 0;
        wr_last = 0;
        ctrl_req = 1'b0;
        req_rd_en = 1'b1;
        req_wr_en = 1'b1;
        req_ratio = '0;
        bp_en = 1'b1;
        reset = 1'b1;
        rd_valid = 1'b0;
        rd_addr = '0;
        rd_vc = vc_map_pkg::VC_VA;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_vc = vc_map_pkg::VC_VA;
        rd_alm_full_in = 1'b0;
        wr_alm_full_in = 1'b0;
        rd_rsp = 1'b0;
        wr_rsp = 1'b0;
        fence_rsp = 1'b0;
        ctrl_valid = 1'b0;
        ctrl_rd_map_en = 1'b0;
        ctrl_wr_map_en = 1'b0;
        ctrl_ratio = '0;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;

        run_traffic(150);
        // Reads pass VA through while writes stay mapped
        write_ctrl(1'b0, 1'b1, 6'd18);
        run_traffic(100);
        remap(6'd40);
        run_traffic(150);
        // With both enables off the ratio changes without a fence
        write_ctrl(1'b0, 1'b0, 6'd7);
        run_traffic(60);
        write_ctrl(1'b1, 1'b1, 6'd7);
        run_traffic(100);
        remap(6'd60);
        run_traffic(150);
        for (int i = 0; i < 30; i++)
        begin
            drive_cycle(1'b0);
        end

        $display("Summary: %0d check errors, %0d timeouts", error_count, timeouts);
        if ((error_count == 0) && (timeouts == 0))
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/vc_map_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module vc_map_checker
(
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   rd_valid,
    input  wire vc_map_pkg::line_addr_t rd_addr,
    input  wire vc_map_pkg::vc_t        rd_vc,
    input  wire logic                   wr_valid,
    input  wire vc_map_pkg::line_addr_t wr_addr,
    input  wire vc_map_pkg::vc_t        wr_vc,
    input  wire logic                   rd_alm_full,
    input  wire logic                   wr_alm_full,
    input  wire logic                   rd_out_valid,
    input  wire vc_map_pkg::line_addr_t rd_out_addr,
    input  wire vc_map_pkg::vc_t        rd_out_vc,
    input  wire logic                   wr_out_valid,
    input  wire vc_map_pkg::line_addr_t wr_out_addr,
    input  wire vc_map_pkg::vc_t        wr_out_vc,
    input  wire logic                   wr_out_fence,
    input  wire logic                   rd_alm_full_in,
    input  wire logic                   wr_alm_full_in,
    input  wire logic                   rd_rsp,
    input  wire logic                   wr_rsp,
    input  wire logic                   fence_rsp,
    input  wire logic                   ctrl_valid,
    input  wire logic                   ctrl_rd_map_en,
    input  wire logic                   ctrl_wr_map_en,
    input  wire vc_map_pkg::ratio_t     ctrl_ratio,
    input  wire vc_map_pkg::ratio_t     ratio,
    input  wire logic                   mapping_changed,
    output int                          error_count
);

    // Model state, updated at the falling edge where every signal is stable
    vc_map_pkg::ratio_t     m_ratio;
    vc_map_pkg::ratio_t     p_ratio;
    vc_map_pkg::ratio_t     new_ratio;
    logic                   m_rd_en;
    logic                   m_wr_en;
    logic                   p_rd_en;
    logic                   p_wr_en;
    logic                   en_pend;
    logic                   ratio_pend;
    logic                   seq_busy;
    logic                   fence_seen;
    logic                   rsp_seen;
    logic                   changed_seen;
    logic                   rsp_prev;
    logic                   was_reset;
    logic                   prev_rd_valid;
    logic                   prev_wr_valid;
    vc_map_pkg::line_addr_t prev_rd_addr;
    vc_map_pkg::line_addr_t prev_wr_addr;
    vc_map_pkg::vc_t        exp_rd_vc;
    vc_map_pkg::vc_t        exp_wr_vc;
    int                     rd_cnt;
    int                     wr_cnt;

    // ====================
    // Reference mapping
    // ====================

    // CRC-32 step over the swizzled low address bits, then the ratio rule
    function automatic vc_map_pkg::vc_t expect_vc(vc_map_pkg::line_addr_t addr,
        vc_map_pkg::vc_t vc, logic en, vc_map_pkg::ratio_t r);
        logic [31:0] d;
        logic [31:0] c;
        logic [5:0]  idx;
        d = {addr[29:4], addr[31:30], addr[3:0]};
        c = 32'hFFFF_FFFF;
        for (int i = 31; i >= 0; i--)
        begin
            if (c[31] ^ d[i])
            begin
                c = {c[30:0], 1'b0} ^ 32'h04C1_1DB7;
            end
            else
            begin
                c = {c[30:0], 1'b0};
            end
        end
        idx = c[5:0];
        if ((vc != vc_map_pkg::VC_VA) || !en)
        begin
            return vc;
        end
        if (idx < r)
        begin
            return vc_map_pkg::VC_VL0;
        end
        return idx[0] ? vc_map_pkg::VC_VH0 : vc_map_pkg::VC_VH1;
    endfunction

    task automatic value_fail(string name, logic [63:0] exp, logic [63:0] act);
        $display("Fail %s: expected %0h, actual %0h at %0t", name, exp, act, $time);
        error_count++;
    endtask

    task automatic plain_fail(string what);
        $display("Error at %0t: %s", $time, what);
        error_count++;
    endtask

    initial
    begin
        error_count = 0;
    end

    // ====================
    // Cycle checks
    // ====================

    always @(negedge clk)
    begin
        if (reset)
        begin
            m_ratio = vc_map_pkg::RATIO_DEFAULT;
            m_rd_en = 1'b1;
            m_wr_en = 1'b1;
            en_pend = 1'b0;
            ratio_pend = 1'b0;
            seq_busy = 1'b0;
            rsp_prev = 1'b0;
            was_reset = 1'b1;
            prev_rd_valid = 1'b0;
            prev_wr_valid = 1'b0;
            rd_cnt = 0;
            wr_cnt = 0;
        end
        else
        begin
            // Control writes from the last cycle are in force now
            if (en_pend)
            begin
                m_rd_en = p_rd_en;
                m_wr_en = p_wr_en;
                en_pend = 1'b0;
            end
            if (ratio_pend)
            begin
                m_ratio = p_ratio;
                ratio_pend = 1'b0;
            end
            if (mapping_changed)
            begin
                if (!seq_busy || !rsp_prev || changed_seen)
                begin
                    plain_fail("mapping_changed pulsed without a preceding fence response");
                end
                m_ratio = new_ratio;
                changed_seen = 1'b1;
            end
            else if (rsp_prev)
            begin
                plain_fail("mapping_changed did not follow the fence response");
            end
            if (fence_rsp && (!fence_seen || rsp_seen))
            begin
                plain_fail("fence response without an outstanding fence");
            end
            rsp_seen = rsp_seen || fence_rsp;
            rsp_prev = fence_rsp;
            if (ratio != m_ratio)
            begin
                value_fail("ratio", m_ratio, ratio);
            end
            if (was_reset && (rd_out_valid || wr_out_valid || mapping_changed))
            begin
                plain_fail("outputs active right after reset");
            end
            was_reset = 1'b0;

            // Read path, one cycle after the request
            if (rd_out_valid != prev_rd_valid)
            begin
                value_fail("rd_out_valid", prev_rd_valid, rd_out_valid);
            end
            if (prev_rd_valid && (rd_out_addr != prev_rd_addr))
            begin
                value_fail("rd_out_addr", prev_rd_addr, rd_out_addr);
            end
            if (prev_rd_valid && (rd_out_vc != exp_rd_vc))
            begin
                value_fail("rd_out_vc", exp_rd_vc, rd_out_vc);
            end

            // Write path, where an idle slot may carry the shim's fence
            if (prev_wr_valid)
            begin
                if (!wr_out_valid || wr_out_fence)
                begin
                    value_fail("wr_out_valid/fence", 2'b10, {wr_out_valid, wr_out_fence});
                end
                if (wr_out_addr != prev_wr_addr)
                begin
                    value_fail("wr_out_addr", prev_wr_addr, wr_out_addr);
                end
                if (wr_out_vc != exp_wr_vc)
                begin
                    value_fail("wr_out_vc", exp_wr_vc, wr_out_vc);
                end
            end
            else if (wr_out_valid)
            begin
                if (!wr_out_fence || (wr_out_addr != '0) || (wr_out_vc != vc_map_pkg::VC_VA))
                begin
                    plain_fail("unexpected write that is not a VA fence to address 0");
                end
                if (!seq_busy || fence_seen)
                begin
                    plain_fail("fence outside a re-mapping sequence or sent twice");
                end
                if (wr_cnt != 0)
                begin
                    plain_fail("fence sent while writes are outstanding");
                end
                fence_seen = 1'b1;
            end

            // Almost-full holds through the sequence until reads drain
            if (seq_busy)
            begin
                if (!rd_alm_full || !wr_alm_full)
                begin
                    if (!changed_seen || (rd_cnt != 0) || rd_alm_full || wr_alm_full)
                    begin
                        plain_fail("almost-full released before the sequence finished");
                    end
                    seq_busy = 1'b0;
                end
            end
            else
            begin
                if (rd_alm_full != rd_alm_full_in)
                begin
                    value_fail("rd_alm_full", rd_alm_full_in, rd_alm_full);
                end
                if (wr_alm_full != wr_alm_full_in)
                begin
                    value_fail("wr_alm_full", wr_alm_full_in, wr_alm_full);
                end
            end

            rd_cnt = rd_cnt + int'(rd_out_valid) - int'(rd_rsp);
            wr_cnt = wr_cnt + int'(wr_out_valid && !wr_out_fence) - int'(wr_rsp);

            // Requests entering now map with the model state of this cycle
            prev_rd_valid = rd_valid;
            prev_rd_addr = rd_addr;
            exp_rd_vc = expect_vc(rd_addr, rd_vc, m_rd_en, m_ratio);
            prev_wr_valid = wr_valid;
            prev_wr_addr = wr_addr;
            exp_wr_vc = expect_vc(wr_addr, wr_vc, m_wr_en, m_ratio);

            if (ctrl_valid && !seq_busy)
            begin
                p_rd_en = ctrl_rd_map_en;
                p_wr_en = ctrl_wr_map_en;
                en_pend = 1'b1;
                if (!ctrl_rd_map_en && !ctrl_wr_map_en)
                begin
                    p_ratio = ctrl_ratio;
                    ratio_pend = 1'b1;
                end
                else if (ctrl_ratio != m_ratio)
                begin
                    new_ratio = ctrl_ratio;
                    seq_busy = 1'b1;
                    fence_seen = 1'b0;
                    rsp_seen = 1'b0;
                    changed_seen = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/vc_active_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module vc_active_tracker
(
    input  wire logic clk,
    input  wire logic reset,

    // One strobe per request sent and per response seen
    input  wire logic note_req,
    input  wire logic note_rsp,

    // Low only when nothing can still be in flight
    output logic      active
);

    localparam int CNT_W = $clog2(vc_map_pkg::MAX_ACTIVE_REQS);

    logic [CNT_W-1:0] count;
    logic             note_req_q;
    logic             note_rsp_q;

    // Both strobes are delayed a cycle to relax timing on the counter
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            note_req_q <= 1'b0;
            note_rsp_q <= 1'b0;
        end
        else
        begin
            note_req_q <= note_req;
            note_rsp_q <= note_rsp;
        end
    end

    // ====================
    // Outstanding count
    // ====================

    // A request and a response in the same cycle cancel out
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= '0;
            active <= 1'b0;
        end
        else
        begin
            if (note_req_q && !note_rsp_q)
            begin
                count <= count + 1'b1;
            end
            else if (!note_req_q && note_rsp_q)
            begin
                count <= count - 1'b1;
            end
            // Requests not yet in the count still keep the flag up
            active <= (|count) || note_req || note_req_q;
        end
    end

endmodule

`default_nettype wire

/* design/vc_address_map.sv */
`timescale 1ns/1ns
`default_nettype none

module vc_address_map
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Request from the client
    input  wire logic                   in_valid,
    input  wire vc_map_pkg::line_addr_t in_addr,
    input  wire vc_map_pkg::vc_t        in_vc,

    // Mapping controls in force this cycle
    input  wire logic                   map_en,
    input  wire vc_map_pkg::ratio_t     ratio,

    // Registered request toward the platform
    output logic                        out_valid,
    output vc_map_pkg::line_addr_t      out_addr,
    output vc_map_pkg::vc_t             out_vc
);

    vc_map_pkg::ratio_t hash_idx;
    vc_map_pkg::vc_t    mapped_vc;

    // ====================
    // Channel choice
    // ====================

    // The choice is made with the ratio of the entry cycle and registered
    // together with the request
    always_comb
    begin
        hash_idx = vc_map_pkg::vc_hash(in_addr);
        mapped_vc = in_vc;
        if ((in_vc == vc_map_pkg::VC_VA) && map_en)
        begin
            if (hash_idx < ratio)
            begin
                mapped_vc = vc_map_pkg::VC_VL0;
            end
            else
            begin
                // The two bus links share the rest evenly
                mapped_vc = hash_idx[0] ? vc_map_pkg::VC_VH0 : vc_map_pkg::VC_VH1;
            end
        end
    end

    // Register the request toward the platform
    always_ff @(posedge clk)
    begin
        out_addr <= in_addr;
        out_vc <= mapped_vc;
        if (reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= in_valid;
        end
    end

endmodule

`default_nettype wire

/* design/vc_fence_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module vc_fence_sequencer
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Control register write
    input  wire logic                   ctrl_valid,
    input  wire logic                   ctrl_rd_map_en,
    input  wire logic                   ctrl_wr_map_en,
    input  wire vc_map_pkg::ratio_t     ctrl_ratio,

    // Mapping state in force
    output logic                        rd_map_en,
    output logic                        wr_map_en,
    output vc_map_pkg::ratio_t          ratio,

    // Registered client write from the write mapper
    input  wire logic                   wr_stage_valid,
    input  wire vc_map_pkg::line_addr_t wr_stage_addr,
    input  wire vc_map_pkg::vc_t        wr_stage_vc,

    input  wire logic                   rd_active,
    input  wire logic                   wr_active,
    input  wire logic                   fence_rsp,
    input  wire logic                   rd_alm_full_in,

    output logic                        block,
    output logic                        wr_out_valid,
    output vc_map_pkg::line_addr_t      wr_out_addr,
    output vc_map_pkg::vc_t             wr_out_vc,
    output logic                        wr_out_fence,
    output logic                        mapping_changed
);

    localparam int SETTLE_W = $clog2(vc_map_pkg::FENCE_SETTLE_CYCLES);

    typedef enum logic [1:0]
    {
        ST_SAMPLING,
        ST_EMIT_FENCE,
        ST_WAIT_FENCE_RSP,
        ST_WAIT_QUIET
    } state_t;

    state_t              state;
    vc_map_pkg::ratio_t  new_ratio;
    logic [SETTLE_W-1:0] settle_cnt;
    logic                fence_rdy;
    logic                emit_fence;

    // ====================
    // Re-mapping FSM
    // ====================

    // A new ratio needs a fence on VA so that no request is left tracked on
    // a channel it no longer maps to
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= ST_SAMPLING;
            block <= 1'b0;
            mapping_changed <= 1'b0;
            rd_map_en <= 1'b1;
            wr_map_en <= 1'b1;
            ratio <= vc_map_pkg::RATIO_DEFAULT;
        end
        else
        begin
            mapping_changed <= 1'b0;
            case (state)
                ST_SAMPLING:
                begin
                    // Writes are only taken while idle
                    if (ctrl_valid)
                    begin
                        rd_map_en <= ctrl_rd_map_en;
                        wr_map_en <= ctrl_wr_map_en;
                        if (!ctrl_rd_map_en && !ctrl_wr_map_en)
                        begin
                            // Nothing is mapped, so the ratio can change at once
                            ratio <= ctrl_ratio;
                        end
                        else if (ctrl_ratio != ratio)
                        begin
                            new_ratio <= ctrl_ratio;
                            block <= 1'b1;
                            state <= ST_EMIT_FENCE;
                        end
                    end
                end
                ST_EMIT_FENCE:
                begin
                    if (emit_fence)
                    begin
                        state <= ST_WAIT_FENCE_RSP;
                    end
                end
                ST_WAIT_FENCE_RSP:
                begin
                    if (fence_rsp)
                    begin
                        ratio <= new_ratio;
                        mapping_changed <= 1'b1;
                        state <= ST_WAIT_QUIET;
                    end
                end
                default:
                begin
                    // Writes drained before the fence, reads may still be out
                    if (!rd_active)
                    begin
                        block <= 1'b0;
                        state <= ST_SAMPLING;
                    end
                end
            endcase
        end
    end

    // ====================
    // Fence readiness
    // ====================

    // Saturating settle count gives the client time to see almost-full
    always_ff @(posedge clk)
    begin
        if (reset || (state != ST_EMIT_FENCE))
        begin
            settle_cnt <= '0;
        end
        else if (!(&settle_cnt))
        begin
            settle_cnt <= settle_cnt + 1'b1;
        end
        if (reset)
        begin
            fence_rdy <= 1'b0;
        end
        else
        begin
            fence_rdy <= !wr_active && !rd_alm_full_in && (&settle_cnt);
        end
    end

    // The fence only takes an idle write slot
    assign emit_fence = (state == ST_EMIT_FENCE) && fence_rdy && !wr_stage_valid;

    // ====================
    // Write output
    // ====================

    always_comb
    begin
        wr_out_valid = wr_stage_valid || emit_fence;
        wr_out_fence = emit_fence;
        wr_out_addr = wr_stage_addr;
        wr_out_vc = wr_stage_vc;
        if (emit_fence)
        begin
            wr_out_addr = '0;
            wr_out_vc = vc_map_pkg::VC_VA;
        end
    end

endmodule

`default_nettype wire

/* design/vc_map_pkg.sv */
`default_nettype none

package vc_map_pkg;

    // ====================
    // Widths and limits
    // ====================

    // Cache-line address width
    localparam int LINE_ADDR_W = 42;

    // The VL0 share is counted in 64ths of all mapped traffic
    localparam int RATIO_W = 6;

    localparam int MAX_ACTIVE_REQS = 128;

    // Cycles with almost-full raised before the shim may emit its fence
    localparam int FENCE_SETTLE_CYCLES = 8;

    localparam logic [31:0] CRC32_POLY = 32'h04C11DB7;

    typedef logic [LINE_ADDR_W-1:0] line_addr_t;
    typedef logic [RATIO_W-1:0] ratio_t;

    // Encoding follows the platform channel select field
    typedef enum logic [1:0]
    {
        VC_VA  = 2'd0,
        VC_VL0 = 2'd1,
        VC_VH0 = 2'd2,
        VC_VH1 = 2'd3
    } vc_t;

    localparam ratio_t RATIO_DEFAULT = ratio_t'(18);

    // ====================
    // Address hash
    // ====================

    // One 32-bit CRC step over the low address bits, so a given line always
    // lands on the same index and therefore on the same channel
    function automatic ratio_t vc_hash(line_addr_t addr);
        logic [31:0] a;
        logic [31:0] swz;
        logic [31:0] crc;
        logic fb;
        a = addr[31:0];
        // Bits 4 and 5 barely reach the low CRC bits, so trade them for high bits
        swz = {a[29:4], a[31:30], a[3:0]};
        crc = '1;
        for (int i = 31; i >= 0; i--)
        begin
            fb = crc[31] ^ swz[i];
            crc = {crc[30:0], 1'b0};
            if (fb)
            begin
                crc = crc ^ CRC32_POLY;
            end
        end
        return crc[RATIO_W-1:0];
    endfunction

endpackage

`default_nettype wire

/* design/vc_map_top.sv */
`timescale 1ns/1ns
`default_nettype none

module vc_map_top
(
    input  wire logic                   clk,
    input  wire logic                   reset,

    // Client side
    input  wire logic                   rd_valid,
    input  wire vc_map_pkg::line_addr_t rd_addr,
    input  wire vc_map_pkg::vc_t        rd_vc,
    input  wire logic                   wr_valid,
    input  wire vc_map_pkg::line_addr_t wr_addr,
    input  wire vc_map_pkg::vc_t        wr_vc,
    output logic                        rd_alm_full,
    output logic                        wr_alm_full,

    // Platform side
    output logic                        rd_out_valid,
    output vc_map_pkg::line_addr_t      rd_out_addr,
    output vc_map_pkg::vc_t             rd_out_vc,
    output logic                        wr_out_valid,
    output vc_map_pkg::line_addr_t      wr_out_addr,
    output vc_map_pkg::vc_t             wr_out_vc,
    output logic                        wr_out_fence,
    input  wire logic                   rd_alm_full_in,
    input  wire logic                   wr_alm_full_in,
    input  wire logic                   rd_rsp,
    input  wire logic                   wr_rsp,
    input  wire logic                   fence_rsp,

    // Control and status
    input  wire logic                   ctrl_valid,
    input  wire logic                   ctrl_rd_map_en,
    input  wire logic                   ctrl_wr_map_en,
    input  wire vc_map_pkg::ratio_t     ctrl_ratio,
    output vc_map_pkg::ratio_t          ratio,
    output logic                        mapping_changed
);

    logic                   rd_map_en;
    logic                   wr_map_en;
    logic                   wr_stage_valid;
    vc_map_pkg::line_addr_t wr_stage_addr;
    vc_map_pkg::vc_t        wr_stage_vc;
    logic                   rd_active;
    logic                   wr_active;
    logic                   block;

    // ====================
    // Request mapping
    // ====================

    vc_address_map i_rd_map
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (rd_valid),
        .in_addr   (rd_addr),
        .in_vc     (rd_vc),
        .map_en    (rd_map_en),
        .ratio     (ratio),
        .out_valid (rd_out_valid),
        .out_addr  (rd_out_addr),
        .out_vc    (rd_out_vc)
    );

    // Writes pass through the sequencer, which may slip a fence in
    vc_address_map i_wr_map
    (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (wr_valid),
        .in_addr   (wr_addr),
        .in_vc     (wr_vc),
        .map_en    (wr_map_en),
        .ratio     (ratio),
        .out_valid (wr_stage_valid),
        .out_addr  (wr_stage_addr),
        .out_vc    (wr_stage_vc)
    );

    // ====================
    // Outstanding tracking
    // ====================

    vc_active_tracker i_rd_tracker
    (
        .clk      (clk),
        .reset    (reset),
        .note_req (rd_out_valid),
        .note_rsp (rd_rsp),
        .active   (rd_active)
    );

    // Client writes only, the shim's own fence is answered on fence_rsp
    vc_active_tracker i_wr_tracker
    (
        .clk      (clk),
        .reset    (reset),
        .note_req (wr_stage_valid),
        .note_rsp (wr_rsp),
        .active   (wr_active)
    );

    vc_fence_sequencer i_sequencer
    (
        .clk             (clk),
        .reset           (reset),
        .ctrl_valid      (ctrl_valid),
        .ctrl_rd_map_en  (ctrl_rd_map_en),
        .ctrl_wr_map_en  (ctrl_wr_map_en),
        .ctrl_ratio      (ctrl_ratio),
        .rd_map_en       (rd_map_en),
        .wr_map_en       (wr_map_en),
        .ratio           (ratio),
        .wr_stage_valid  (wr_stage_valid),
        .wr_stage_addr   (wr_stage_addr),
        .wr_stage_vc     (wr_stage_vc),
        .rd_active       (rd_active),
        .wr_active       (wr_active),
        .fence_rsp       (fence_rsp),
        .rd_alm_full_in  (rd_alm_full_in),
        .block           (block),
        .wr_out_valid    (wr_out_valid),
        .wr_out_addr     (wr_out_addr),
        .wr_out_vc       (wr_out_vc),
        .wr_out_fence    (wr_out_fence),
        .mapping_changed (mapping_changed)
    );

    // Platform back-pressure plus the re-mapping hold
    assign rd_alm_full = rd_alm_full_in || block;
    assign wr_alm_full = wr_alm_full_in || block;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -Wno-fatal --top-module tb_vc_map -f sim.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_vc_map > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "Test OK" sim.log && exit 0 || exit 1

/* sim.f */
design/vc_map_pkg.sv
design/vc_address_map.sv
design/vc_active_tracker.sv
design/vc_fence_sequencer.sv
design/vc_map_top.sv
bench/vc_map_checker.sv
bench/tb_vc_map.sv
